/* hw/pkt_pkg.sv */
/*
 * Fabric packet layout for single-beat commands and responses.
 * Bits 79:77 are reserved. Responses always carry zeros there.
 */
package pkt_pkg;

    // --------------------------------------------------
    // packet field positions
    // --------------------------------------------------
    localparam int PKT_W = 82;

    // write data on commands and read data on responses share the low field
    localparam int PKT_DATA_L       = 0;
    localparam int PKT_DATA_H       = 31;
    localparam int PKT_ADDR_L       = 32;
    localparam int PKT_ADDR_H       = 63;
    localparam int PKT_BYTEEN_L     = 64;
    localparam int PKT_BYTEEN_H     = 67;
    localparam int PKT_TRANS_READ   = 68;
    localparam int PKT_TRANS_WRITE  = 69;
    localparam int PKT_TRANS_POSTED = 70;
    localparam int PKT_SRC_ID_L     = 71;
    localparam int PKT_SRC_ID_H     = 73;
    localparam int PKT_DEST_ID_L    = 74;
    localparam int PKT_DEST_ID_H    = 76;
    localparam int PKT_RESPONSE_L   = 80;
    localparam int PKT_RESPONSE_H   = 81;

    // field widths derived from the positions above
    localparam int ID_W       = PKT_SRC_ID_H - PKT_SRC_ID_L + 1;
    localparam int PKT_ADDR_W = PKT_ADDR_H - PKT_ADDR_L + 1;
    localparam int PKT_BE_W   = PKT_BYTEEN_H - PKT_BYTEEN_L + 1;

    // --------------------------------------------------
    // tracking record, one per command that expects a response
    // --------------------------------------------------
    // synth marks a response the agent makes up itself, without slave data
    // addr keeps the address as it came in, before the low bits are cleared
    typedef struct packed {
        logic                  synth;
        logic                  read;
        logic                  write;
        logic                  posted;
        logic [ID_W-1:0]       src_id;
        logic [ID_W-1:0]       dest_id;
        logic [PKT_BE_W-1:0]   byteen;
        logic [PKT_ADDR_W-1:0] addr;
    } cmd_rec_t;

endpackage

/* hw/avs_pkg.sv */
/*
 * Memory-mapped slave port widths, response codes and read-data record.
 * TRACK_DEPTH bounds the commands in flight and sizes both FIFOs.
 */
package avs_pkg;

    // --------------------------------------------------
    // slave port widths
    // --------------------------------------------------
    localparam int AVS_DATA_W = 32;
    localparam int AVS_ADDR_W = 32;
    localparam int SYMBOL_W   = 8;
    localparam int AVS_BE_W   = AVS_DATA_W / SYMBOL_W;

    // addresses seen by the slave are aligned to the full data width
    localparam int ADDR_MASK_BITS = $clog2(AVS_BE_W);

    // --------------------------------------------------
    // response status
    // --------------------------------------------------
    localparam int RSP_W = 2;

    localparam logic [RSP_W-1:0] RSP_OKAY     = 2'd0;
    localparam logic [RSP_W-1:0] RSP_RESERVED = 2'd1;
    localparam logic [RSP_W-1:0] RSP_SLVERR   = 2'd2;
    localparam logic [RSP_W-1:0] RSP_DECERR   = 2'd3;

    // number of tracked commands, and so the most reads outstanding
    localparam int TRACK_DEPTH = 4;

    // one entry per read-data pulse from the slave
    typedef struct packed {
        logic [RSP_W-1:0]      status;
        logic [AVS_DATA_W-1:0] data;
    } rd_rec_t;

endpackage

/* hw/sync_fifo.sv */
/*
 * Show-ahead FIFO: the head entry is always on rdata. DEPTH must be 2 or more.
 * A push while full or a pop while empty is dropped.
 */
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = avs_pkg::TRACK_DEPTH
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t wdata,
    input  logic     pop,
    output payload_t rdata,
    output logic     empty,
    output logic     full
);

    // storage has no reset, the count alone says which entries are live
    payload_t mem [DEPTH];

    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == 0);
    assign full  = (count == DEPTH);
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap by compare so that DEPTH need not be a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // a push and a pop in the same cycle leave the count unchanged
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* hw/cmd_decoder.sv */
/*
 * Command side of the agent, purely combinational. Packets must be single beat
 * and carry exactly one of the read and write flags.
 */
`timescale 1ns/1ps

module cmd_decoder (
    input  logic                          cp_valid,
    input  logic [pkt_pkg::PKT_W-1:0]     cp_data,
    output logic                          cp_ready,
    input  logic                          m0_waitrequest,
    output logic                          m0_read,
    output logic                          m0_write,
    output logic [avs_pkg::AVS_ADDR_W-1:0] m0_address,
    output logic [avs_pkg::AVS_BE_W-1:0]   m0_byteenable,
    output logic [avs_pkg::AVS_DATA_W-1:0] m0_writedata,
    input  logic                          track_full,
    output logic                          track_push,
    output pkt_pkg::cmd_rec_t             track_rec
);

    import pkt_pkg::*;
    import avs_pkg::*;

    // --------------------------------------------------
    // command fields
    // --------------------------------------------------
    logic [AVS_DATA_W-1:0] cmd_data;
    logic [AVS_ADDR_W-1:0] cmd_addr;
    logic [AVS_BE_W-1:0]   cmd_byteen;
    logic [ID_W-1:0]       cmd_src_id;
    logic [ID_W-1:0]       cmd_dest_id;
    logic                  cmd_read;
    logic                  cmd_write;
    logic                  cmd_posted;
    logic                  byteen_asserted;
    logic                  needs_track;

    assign cmd_data    = cp_data[PKT_DATA_H:PKT_DATA_L];
    assign cmd_addr    = cp_data[PKT_ADDR_H:PKT_ADDR_L];
    assign cmd_byteen  = cp_data[PKT_BYTEEN_H:PKT_BYTEEN_L];
    assign cmd_src_id  = cp_data[PKT_SRC_ID_H:PKT_SRC_ID_L];
    assign cmd_dest_id = cp_data[PKT_DEST_ID_H:PKT_DEST_ID_L];
    assign cmd_read    = cp_data[PKT_TRANS_READ];
    assign cmd_write   = cp_data[PKT_TRANS_WRITE];
    assign cmd_posted  = cp_data[PKT_TRANS_POSTED];

    // a command with no byte lanes enabled never reaches the slave
    assign byteen_asserted = |cmd_byteen;

    // --------------------------------------------------
    // back-pressure
    // --------------------------------------------------
    // every command stalls while the tracking FIFO is full, even posted
    // writes that would not use a slot, so ready does not depend on the kind
    // of command. a suppressed command has nothing to wait on at the slave
    assign cp_ready = !track_full && (!byteen_asserted || !m0_waitrequest);

    // --------------------------------------------------
    // slave strobes
    // --------------------------------------------------
    // strobes stay up while waitrequest holds them, the packet is held too
    assign m0_read  = cp_valid && cmd_read && byteen_asserted && !track_full;
    assign m0_write = cp_valid && cmd_write && byteen_asserted && !track_full;

    // clear the lanes below the data width, e.g. 0x6 goes out as 0x4
    assign m0_address    = {cmd_addr[AVS_ADDR_W-1:ADDR_MASK_BITS], {ADDR_MASK_BITS{1'b0}}};
    assign m0_byteenable = cmd_byteen;
    assign m0_writedata  = cmd_data;

    // --------------------------------------------------
    // tracking record
    // --------------------------------------------------
    // reads always answer, writes only when not posted
    assign needs_track = cmd_read || (cmd_write && !cmd_posted);
    assign track_push  = cp_valid && cp_ready && needs_track;

    always_comb begin
        // the slave never sees a suppressed read, and no slave write response
        // is used, so both of these get a response made up by the assembler
        track_rec.synth   = (cmd_read && !byteen_asserted) || (cmd_write && !cmd_posted);
        track_rec.read    = cmd_read;
        track_rec.write   = cmd_write;
        track_rec.posted  = cmd_posted;
        track_rec.src_id  = cmd_src_id;
        track_rec.dest_id = cmd_dest_id;
        track_rec.byteen  = cmd_byteen;
        // the response returns the address unmasked, as the master sent it
        track_rec.addr    = cmd_addr;
    end

endmodule

/* hw/rsp_assembler.sv */
/*
 * Builds response packets from the head of the tracking FIFO, with read data
 * when the command reached the slave. Responses leave in command order.
 */
`timescale 1ns/1ps

module rsp_assembler (
    input  pkt_pkg::cmd_rec_t          track_rec,
    input  logic                       track_empty,
    output logic                       track_pop,
    input  avs_pkg::rd_rec_t           rd_rec,
    input  logic                       rd_empty,
    output logic                       rd_pop,
    output logic                       rp_valid,
    output logic [pkt_pkg::PKT_W-1:0]  rp_data,
    input  logic                       rp_ready
);

    import pkt_pkg::*;
    import avs_pkg::*;

    // --------------------------------------------------
    // response handshake
    // --------------------------------------------------
    logic                  rsp_done;
    logic [AVS_DATA_W-1:0] rsp_payload;
    logic [RSP_W-1:0]      rsp_status;

    // a read that went to the slave waits for its data, anything flagged
    // synth can go as soon as it reaches the head
    assign rp_valid = !track_empty && (track_rec.synth || !rd_empty);

    assign rsp_done  = rp_valid && rp_ready;
    assign track_pop = rsp_done;

    // read data stays queued behind a synthesized response, since it
    // belongs to a later read
    assign rd_pop = rsp_done && !track_rec.synth;

    // --------------------------------------------------
    // data and status
    // --------------------------------------------------
    // synthesized responses always report OKAY with empty data
    assign rsp_payload = track_rec.synth ? '0 : rd_rec.data;
    assign rsp_status  = track_rec.synth ? RSP_OKAY : rd_rec.status;

    // --------------------------------------------------
    // response packet
    // --------------------------------------------------
    // both FIFO heads hold still until popped, so rp_data is stable while
    // rp_ready is low
    always_comb begin
        // reserved bits go out as zero
        rp_data = '0;

        rp_data[PKT_DATA_H:PKT_DATA_L]         = rsp_payload;
        rp_data[PKT_RESPONSE_H:PKT_RESPONSE_L] = rsp_status;

        // flags, lanes and address come back as the command had them
        rp_data[PKT_ADDR_H:PKT_ADDR_L]     = track_rec.addr;
        rp_data[PKT_BYTEEN_H:PKT_BYTEEN_L] = track_rec.byteen;
        rp_data[PKT_TRANS_READ]            = track_rec.read;
        rp_data[PKT_TRANS_WRITE]           = track_rec.write;
        rp_data[PKT_TRANS_POSTED]          = track_rec.posted;

        // the response heads back to the master, so the IDs trade places
        rp_data[PKT_SRC_ID_H:PKT_SRC_ID_L]   = track_rec.dest_id;
        rp_data[PKT_DEST_ID_H:PKT_DEST_ID_L] = track_rec.src_id;
    end

endmodule

/* hw/slave_agent.sv */
/*
 * Slave agent top: single-beat command packets in, slave strobes out,
 * one response per read or non-posted write. Slave read data must be in order.
 */
`timescale 1ns/1ps

module slave_agent (
    input  logic                           clk,
    input  logic                           reset,

    // command sink
    input  logic                           cp_valid,
    input  logic [pkt_pkg::PKT_W-1:0]      cp_data,
    output logic                           cp_ready,

    // slave port
    output logic                           m0_read,
    output logic                           m0_write,
    output logic [avs_pkg::AVS_ADDR_W-1:0] m0_address,
    output logic [avs_pkg::AVS_BE_W-1:0]   m0_byteenable,
    output logic [avs_pkg::AVS_DATA_W-1:0] m0_writedata,
    input  logic                           m0_waitrequest,
    input  logic [avs_pkg::AVS_DATA_W-1:0] m0_readdata,
    input  logic [avs_pkg::RSP_W-1:0]      m0_response,
    input  logic                           m0_readdatavalid,

    // response source
    output logic                           rp_valid,
    output logic [pkt_pkg::PKT_W-1:0]      rp_data,
    input  logic                           rp_ready
);

    import pkt_pkg::*;
    import avs_pkg::*;

    logic     track_push;
    logic     track_pop;
    logic     track_full;
    logic     track_empty;
    cmd_rec_t track_in_rec;
    cmd_rec_t track_head;

    logic     rd_pop;
    logic     rd_empty;
    rd_rec_t  rd_in_rec;
    rd_rec_t  rd_head;

    // status rides above the data in the read-data record
    assign rd_in_rec.status = m0_response;
    assign rd_in_rec.data   = m0_readdata;

    cmd_decoder u_cmd_decoder (
        .cp_valid       (cp_valid),
        .cp_data        (cp_data),
        .cp_ready       (cp_ready),
        .m0_waitrequest (m0_waitrequest),
        .m0_read        (m0_read),
        .m0_write       (m0_write),
        .m0_address     (m0_address),
        .m0_byteenable  (m0_byteenable),
        .m0_writedata   (m0_writedata),
        .track_full     (track_full),
        .track_push     (track_push),
        .track_rec      (track_in_rec)
    );

    sync_fifo #(.payload_t(cmd_rec_t), .DEPTH(TRACK_DEPTH)) track_fifo (
        .clk   (clk),
        .reset (reset),
        .push  (track_push),
        .wdata (track_in_rec),
        .pop   (track_pop),
        .rdata (track_head),
        .empty (track_empty),
        .full  (track_full)
    );

    // every outstanding read holds a tracking slot, so this FIFO cannot fill
    // past TRACK_DEPTH and its full flag is not needed
    sync_fifo #(.payload_t(rd_rec_t), .DEPTH(TRACK_DEPTH)) rdata_fifo (
        .clk   (clk),
        .reset (reset),
        .push  (m0_readdatavalid),
        .wdata (rd_in_rec),
        .pop   (rd_pop),
        .rdata (rd_head),
        .empty (rd_empty),
        .full  ()
    );

    rsp_assembler u_rsp_assembler (
        .track_rec   (track_head),
        .track_empty (track_empty),
        .track_pop   (track_pop),
        .rd_rec      (rd_head),
        .rd_empty    (rd_empty),
        .rd_pop      (rd_pop),
        .rp_valid    (rp_valid),
        .rp_data     (rp_data),
        .rp_ready    (rp_ready)
    );

endmodule

/* sim/slave_agent_props.sv */
/*
 * Protocol checks on the slave port and the response source of slave_agent.
 * All checks are off while reset is high.
 */
`timescale 1ns/1ps

module slave_agent_props (
    input logic                         clk,
    input logic                         reset,
    input logic                         m0_read,
    input logic                         m0_write,
    input logic [avs_pkg::AVS_BE_W-1:0] m0_byteenable,
    input logic                         rp_valid,
    input logic                         rp_ready,
    input logic [pkt_pkg::PKT_W-1:0]    rp_data
);

    // number of assertion failures so far
    int fail_count = 0;

    // one command is either a read or a write and never both
    rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(m0_read && m0_write))
        else begin
            $error("m0_read and m0_write are high together");
            fail_count++;
        end

    // a command without byte lanes is suppressed and must not reach the slave
    strobe_needs_lanes: assert property (@(posedge clk) disable iff (reset)
        (m0_read || m0_write) |-> (m0_byteenable != '0))
        else begin
            $error("slave strobe raised with all byte enables low");
            fail_count++;
        end

    // a stalled response stays put until the sink takes it
    rsp_holds: assert property (@(posedge clk) disable iff (reset)
        (rp_valid && !rp_ready) |=> (rp_valid && $stable(rp_data)))
        else begin
            $error("response dropped or changed while rp_ready was low");
            fail_count++;
        end

endmodule

bind slave_agent slave_agent_props u_props (
    .clk           (clk),
    .reset         (reset),
    .m0_read       (m0_read),
    .m0_write      (m0_write),
    .m0_byteenable (m0_byteenable),
    .rp_valid      (rp_valid),
    .rp_ready      (rp_ready),
    .rp_data       (rp_data)
);

/* sim/tb_slave_agent.sv */
/*
 * Testbench for slave_agent with a random slave model and random response
 * back-pressure. The slave model returns reads in order.
 */
`timescale 1ns/1ps

module tb_slave_agent;

    import pkt_pkg::*;
    import avs_pkg::*;

    localparam int WAIT_LIMIT = 400;

    // one expected slave access, as the slave port should show it
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [AVS_ADDR_W-1:0] addr;
        logic [AVS_BE_W-1:0]   be;
        logic [AVS_DATA_W-1:0] data;
    } slv_op_t;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  cp_valid;
    logic [PKT_W-1:0]      cp_data;
    logic                  cp_ready;
    logic                  m0_read;
    logic                  m0_write;
    logic [AVS_ADDR_W-1:0] m0_address;
    logic [AVS_BE_W-1:0]   m0_byteenable;
    logic [AVS_DATA_W-1:0] m0_writedata;
    logic                  m0_waitrequest;
    logic [AVS_DATA_W-1:0] m0_readdata;
    logic [RSP_W-1:0]      m0_response;
    logic                  m0_readdatavalid;
    logic                  rp_valid;
    logic [PKT_W-1:0]      rp_data;
    logic                  rp_ready;

    int               seed = 13423;
    int               errors = 0;
    int               tests = 0;
    int               responses = 0;
    int               errs_base = 0;
    int               props_seen = 0;
    logic             rand_wait = 1'b0;
    logic             rand_ready = 1'b0;
    slv_op_t          exp_ops [$];
    // expected responses in command order with a flag for data from the slave
    logic [PKT_W-1:0] exp_rsp [$];
    logic             exp_from_slave [$];
    // reads still to be returned by the slave model, and all it has returned
    rd_rec_t          pend_q [$];
    int               delay_q [$];
    rd_rec_t          slv_rd_q [$];
    slv_op_t          op;
    rd_rec_t          rd;
    rd_rec_t          got_rd;
    logic [PKT_W-1:0] want;

    slave_agent uut (.*);

    always #20 clk = ~clk;

    // the expected response swaps the IDs and copies the flags, lanes and raw address
    // data and status stay 0 (OKAY) unless the slave supplied them
    function automatic logic [PKT_W-1:0] expect_rsp(input logic [PKT_W-1:0] cmd);
        logic [PKT_W-1:0] r;
        r = '0;
        r[PKT_ADDR_H:PKT_ADDR_L]             = cmd[PKT_ADDR_H:PKT_ADDR_L];
        r[PKT_BYTEEN_H:PKT_BYTEEN_L]         = cmd[PKT_BYTEEN_H:PKT_BYTEEN_L];
        r[PKT_TRANS_POSTED:PKT_TRANS_READ]   = cmd[PKT_TRANS_POSTED:PKT_TRANS_READ];
        r[PKT_SRC_ID_H:PKT_SRC_ID_L]         = cmd[PKT_DEST_ID_H:PKT_DEST_ID_L];
        r[PKT_DEST_ID_H:PKT_DEST_ID_L]       = cmd[PKT_SRC_ID_H:PKT_SRC_ID_L];
        return r;
    endfunction

    // --------------------------------------------------
    // command stimulus
    // --------------------------------------------------
    task automatic send_cmd(input logic rd_f, input logic wr_f, input logic posted,
                            input logic [AVS_BE_W-1:0] be,
                            input logic [AVS_ADDR_W-1:0] addr,
                            input logic [AVS_DATA_W-1:0] data);
        logic [PKT_W-1:0] pkt;
        slv_op_t          sop;
        logic             taken;
        int               cycles;
        pkt = '0;
        pkt[PKT_DATA_H:PKT_DATA_L]       = data;
        pkt[PKT_ADDR_H:PKT_ADDR_L]       = addr;
        pkt[PKT_BYTEEN_H:PKT_BYTEEN_L]   = be;
        pkt[PKT_TRANS_READ]              = rd_f;
        pkt[PKT_TRANS_WRITE]             = wr_f;
        pkt[PKT_TRANS_POSTED]            = posted;
        pkt[PKT_SRC_ID_H:PKT_SRC_ID_L]   = ID_W'($random(seed));
        pkt[PKT_DEST_ID_H:PKT_DEST_ID_L] = ID_W'($random(seed));
        // only commands with lanes enabled reach the slave at a word-aligned address
        if (be != '0) begin
            sop = '{rd_f, wr_f, addr & ~((1 << ADDR_MASK_BITS) - 1), be, data};
            exp_ops.push_back(sop);
        end
        if (rd_f || (wr_f && !posted)) begin
            exp_rsp.push_back(expect_rsp(pkt));
            exp_from_slave.push_back(rd_f && be != '0);
        end
        cp_data  = pkt;
        cp_valid = 1'b1;
        taken    = 1'b0;
        cycles   = 0;
        while (!taken && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            taken = cp_ready;
            cycles++;
            #1;
        end
        cp_valid = 1'b0;
        if (!taken) begin
            $display("timeout: command %h was never accepted by the agent", pkt);
            errors++;
        end
    endtask

    // wait until every expected slave access and response has been seen
    task automatic finish_test(input string name);
        int cycles;
        cycles = 0;
        while ((exp_rsp.size() != 0 || exp_ops.size() != 0) && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
            #1;
        end
        if (exp_rsp.size() != 0 || exp_ops.size() != 0) begin
            $display("timeout: %0d responses and %0d slave accesses never came",
                     exp_rsp.size(), exp_ops.size());
            errors++;
        end
        errors     = errors + uut.u_props.fail_count - props_seen;
        props_seen = uut.u_props.fail_count;
        tests++;
        if (errors == errs_base)
            $display("test %0d %s: ok", tests, name);
        else
            $display("test %0d %s: %0d error(s)", tests, name, errors - errs_base);
        errs_base = errors;
    endtask

    // --------------------------------------------------
    // the slave model samples at the edge and drives just after it
    // --------------------------------------------------
    always @(posedge clk) begin
        if (!reset && (m0_read || m0_write)) begin
            if (exp_ops.size() == 0) begin
                $display("FAILED at %0t: slave strobe with no access expected", $time);
                errors++;
            end else begin
                op = exp_ops[0];
                assert (m0_read == op.read && m0_write == op.write && m0_address == op.addr
                        && m0_byteenable == op.be && (!op.write || m0_writedata == op.data))
                else begin
                    $display("FAILED at %0t: slave saw addr %h be %h data %h, expected %h %h %h",
                             $time, m0_address, m0_byteenable, m0_writedata,
                             op.addr, op.be, op.data);
                    errors++;
                end
                if (!m0_waitrequest) begin
                    op = exp_ops.pop_front();
                    if (m0_read) begin
                        rd.data   = $random(seed);
                        rd.status = RSP_W'($random(seed));
                        pend_q.push_back(rd);
                        delay_q.push_back($random(seed) & 3);
                        slv_rd_q.push_back(rd);
                    end
                end
            end
        end
        #1;
        m0_readdatavalid = 1'b0;
        if (pend_q.size() != 0) begin
            if (delay_q[0] == 0) begin
                rd               = pend_q.pop_front();
                void'(delay_q.pop_front());
                m0_readdata      = rd.data;
                m0_response      = rd.status;
                m0_readdatavalid = 1'b1;
            end else begin
                delay_q[0] = delay_q[0] - 1;
            end
        end
        m0_waitrequest = rand_wait ? (($random(seed) & 3) == 0) : 1'b0;
        rp_ready       = rand_ready ? 1'($random(seed)) : 1'b1;
    end

    // each accepted response is compared with the oldest expectation
    always @(posedge clk) begin
        if (!reset && rp_valid && rp_ready) begin
            responses++;
            if (exp_rsp.size() == 0) begin
                $display("FAILED at %0t: unexpected response %h", $time, rp_data);
                errors++;
            end else begin
                want = exp_rsp.pop_front();
                if (exp_from_slave.pop_front()) begin
                    if (slv_rd_q.size() == 0) begin
                        $display("FAILED at %0t: response for a read the slave never took",
                                 $time);
                        errors++;
                    end else begin
                        got_rd = slv_rd_q.pop_front();
                        want[PKT_DATA_H:PKT_DATA_L]         = got_rd.data;
                        want[PKT_RESPONSE_H:PKT_RESPONSE_L] = got_rd.status;
                    end
                end
                assert (rp_data == want)
                else begin
                    $display("FAILED at %0t: response %h, expected %h", $time, rp_data, want);
                    errors++;
                end
            end
        end
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        int                  i;
        int                  kind;
        logic [AVS_BE_W-1:0] be;
        reset            = 1'b1;
        cp_valid         = 1'b0;
        cp_data          = '0;
        m0_waitrequest   = 1'b0;
        m0_readdata      = '0;
        m0_response      = '0;
        m0_readdatavalid = 1'b0;
        rp_ready         = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        send_cmd(1'b0, 1'b1, 1'b1, 4'b0110, 32'h1000_0007, 32'ha5a5_1234);
        finish_test("posted write");
        send_cmd(1'b0, 1'b1, 1'b0, 4'hf, 32'h2000_0012, 32'hdead_beef);
        finish_test("non-posted write");
        send_cmd(1'b1, 1'b0, 1'b0, 4'hf, 32'h3000_0022, 32'h0);
        finish_test("read");
        // none of these may touch the slave
        // the read and the non-posted write still get a response
        send_cmd(1'b1, 1'b0, 1'b0, 4'h0, 32'h4000_0001, 32'h0);
        send_cmd(1'b0, 1'b1, 1'b1, 4'h0, 32'h4000_0005, 32'h1111_2222);
        send_cmd(1'b0, 1'b1, 1'b0, 4'h0, 32'h4000_0009, 32'h3333_4444);
        finish_test("zero byte enables");

        // kinds 0 and 3 read, 1 is a posted write, 2 a non-posted write
        rand_wait  = 1'b1;
        rand_ready = 1'b1;
        for (i = 0; i < 60; i++) begin
            kind = $random(seed) & 3;
            be   = AVS_BE_W'($random(seed));
            if (($random(seed) & 7) == 0)
                be = '0;
            send_cmd(kind == 0 || kind == 3, kind == 1 || kind == 2, kind == 1, be,
                     $random(seed), $random(seed));
        end
        finish_test("random mix");
        rand_wait  = 1'b0;
        rand_ready = 1'b0;

        $display("tests: %0d, responses checked: %0d, errors: %0d", tests, responses, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* slave_agent.f */
hw/pkt_pkg.sv
hw/avs_pkg.sv
hw/sync_fifo.sv
hw/cmd_decoder.sv
hw/rsp_assembler.sv
hw/slave_agent.sv
sim/slave_agent_props.sv
sim/tb_slave_agent.sv

/* Makefile */
# Verilator build and run for the slave agent testbench

VERILATOR ?= verilator
TOP       ?= tb_slave_agent
FLIST     ?= slave_agent.f
MDIR      ?= obj_dir
VFLAGS    ?= --binary --assert --timing -Wno-fatal
SIMARGS   ?= +verilator+error+limit+1000
LOG       ?= sim.log
FAIL_MSG  := Finished with errors

SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(MDIR)/V%: $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -Mdir $(MDIR) -f $(FLIST)

run: $(MDIR)/V$(TOP)
	./$(MDIR)/V$(TOP) $(SIMARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(MDIR) $(LOG)
